// ==== test/axi_mem_testdata.hex ====
// columns: op addr arg data resp, one record per line
// op 1 write, 5 address first, 6 data first, 3 uart, 2 read (arg is arlen), 4 beat, 0 end
00000001 30000000 0000000f 11223344 00000000
00000001 30000004 0000000f 55667788 00000000
00000001 30000008 0000000f 99aabbcc 00000000
00000001 3000000c 0000000f ddeeff00 00000000
00000001 a0000000 0000000f cafef00d 00000000
00000002 a0000000 00000000 00000000 00000000
00000004 00000000 00000000 cafef00d 00000000
00000001 a0000000 00000005 12345678 00000000
00000002 a0000000 00000000 00000000 00000000
00000004 00000000 00000000 ca34f078 00000000
00000002 30000000 00000003 00000000 00000000
00000004 00000000 00000000 11223344 00000000
00000004 00000000 00000000 55667788 00000000
00000004 00000000 00000000 99aabbcc 00000000
00000004 00000000 00000000 ddeeff00 00000000
00000002 3000000c 00000000 00000000 00000000
00000004 00000000 00000000 ddeeff00 00000000
00000001 40000000 0000000f deadbeef 00000002
00000002 40000000 00000000 00000000 00000000
00000004 00000000 00000000 00000000 00000002
00000001 a00000f8 0000000f 0badc0de 00000000
00000001 a00000fc 0000000f 600df00d 00000000
00000002 a00000f8 00000003 00000000 00000000
00000004 00000000 00000000 0badc0de 00000000
00000004 00000000 00000000 600df00d 00000000
00000004 00000000 00000000 00000000 00000002
00000004 00000000 00000000 00000000 00000002
00000003 10000000 0000000f 00000048 00000000
00000003 10000000 0000000f 00000069 00000000
00000002 10000000 00000000 00000000 00000000
00000004 00000000 00000000 00000000 00000002
00000005 a0000010 0000000f 01010101 00000000
00000006 a0000014 0000000f 02020202 00000000
00000001 a0000018 0000000f 03030303 00000000
00000002 a0000010 00000002 00000000 00000000
00000004 00000000 00000000 01010101 00000000
00000004 00000000 00000000 02020202 00000000
00000004 00000000 00000000 03030303 00000000
00000000 00000000 00000000 00000000 00000000

// ==== project.f ====
design/soc_mem_pkg.sv
design/addr_region_decode.sv
design/mem_bank.sv
design/axi_read_engine.sv
design/axi_write_engine.sv
design/axi_mem_top.sv
test/axi_mem_asserts.sv
test/tb_axi_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_axi_mem -Mdir obj_dir -f project.f \
    && ./obj_dir/Vtb_axi_mem > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "test passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== test/tb_axi_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem;

    localparam soc_mem_pkg::addr_t FLASH_BASE  = 32'h3000_0000;
    localparam int unsigned        FLASH_WORDS = 256;
    localparam soc_mem_pkg::addr_t SDRAM_BASE  = 32'ha000_0000;
    localparam int unsigned        SDRAM_WORDS = 64;
    localparam soc_mem_pkg::addr_t UART_BASE   = 32'h1000_0000;

    localparam int MAX_RECORDS       = 64;
    localparam int CYCLES_PER_RECORD = 60;

    // record opcodes in the data file
    localparam logic [31:0] OP_END       = 32'h0;
    localparam logic [31:0] OP_WRITE     = 32'h1;
    localparam logic [31:0] OP_READ      = 32'h2;
    localparam logic [31:0] OP_UART      = 32'h3;
    localparam logic [31:0] OP_BEAT      = 32'h4;
    localparam logic [31:0] OP_WR_AFIRST = 32'h5;
    localparam logic [31:0] OP_WR_DFIRST = 32'h6;

    logic               clock;
    logic               rst_n;
    soc_mem_pkg::addr_t araddr;
    soc_mem_pkg::len_t  arlen;
    logic               arvalid;
    logic               arready;
    soc_mem_pkg::data_t rdata;
    soc_mem_pkg::resp_t rresp;
    logic               rlast;
    logic               rvalid;
    logic               rready;
    soc_mem_pkg::addr_t awaddr;
    logic               awvalid;
    logic               awready;
    soc_mem_pkg::data_t wdata;
    soc_mem_pkg::strb_t wstrb;
    logic               wvalid;
    logic               wready;
    soc_mem_pkg::resp_t bresp;
    logic               bvalid;
    logic               bready;
    logic [7:0]         uart_data;
    logic               uart_valid;

    logic [31:0] records [MAX_RECORDS*5];
    logic [7:0]  uart_seen [$];
    integer      seed;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    string       test_name;

    axi_mem_top #(
        .FLASH_BASE  (FLASH_BASE),
        .FLASH_WORDS (FLASH_WORDS),
        .SDRAM_BASE  (SDRAM_BASE),
        .SDRAM_WORDS (SDRAM_WORDS),
        .UART_BASE   (UART_BASE)
    ) dut (
        .clock      (clock),
        .rst_n      (rst_n),
        .araddr     (araddr),
        .arlen      (arlen),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .uart_data  (uart_data),
        .uart_valid (uart_valid)
    );

    bind axi_mem_top axi_mem_asserts asserts (
        .clock      (clock),
        .rst_n      (rst_n),
        .rdata      (rdata),
        .rresp      (rresp),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .uart_valid (uart_valid)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            stop_run($sformatf("timeout after %0d cycles, the DUT stopped answering",
                               cycle_count));
        end
    end

    // uart pulse is a full cycle wide, so one negedge sees it
    always @(negedge clock) begin
        if (rst_n && uart_valid) begin
            uart_seen.push_back(uart_data);
        end
    end

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            stop_run($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic send_addr(input logic [31:0] addr);
        awaddr  = addr;
        awvalid = 1'b1;
        do @(negedge clock); while (!awready);
        step();
        awvalid = 1'b0;
    endtask

    task automatic send_data(input logic [31:0] data, input logic [3:0] strb);
        wdata  = data;
        wstrb  = strb;
        wvalid = 1'b1;
        do @(negedge clock); while (!wready);
        step();
        wvalid = 1'b0;
    endtask

    task automatic send_both(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic aw_taken;
        logic w_taken;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = strb;
        wvalid  = 1'b1;
        while (awvalid || wvalid) begin
            @(negedge clock);
            aw_taken = awvalid && awready;
            w_taken  = wvalid && wready;
            step();
            if (aw_taken) begin
                awvalid = 1'b0;
            end
            if (w_taken) begin
                wvalid = 1'b0;
            end
        end
    endtask

    // random stall on bready before taking the response
    task automatic take_bresp(input logic [31:0] expected);
        int stall;
        stall  = $random(seed) & 3;
        bready = 1'b0;
        repeat (stall) step();
        bready = 1'b1;
        do @(negedge clock); while (!bvalid);
        check_value($sformatf("%s bresp", test_name), expected, 32'(bresp));
        step();
        bready = 1'b0;
    endtask

    task automatic run_read(input int at, input logic [31:0] addr, input logic [31:0] len);
        int n_beats;
        int stall;
        int b;
        int exp_at;
        n_beats = int'(len[7:0]) + 1;
        araddr  = addr;
        arlen   = len[7:0];
        arvalid = 1'b1;
        do @(negedge clock); while (!arready);
        step();
        arvalid = 1'b0;
        for (b = 0; b < n_beats; b++) begin
            exp_at = (at + 1 + b) * 5;
            test_name = $sformatf("record %0d read %h beat %0d", at, addr, b);
            assert (records[exp_at] == OP_BEAT) else begin
                stop_run($sformatf("record %0d should hold a beat expectation", at + 1 + b));
            end
            stall  = $random(seed) & 3;
            rready = 1'b0;
            repeat (stall) step();
            rready = 1'b1;
            do @(negedge clock); while (!rvalid);
            check_value($sformatf("%s rdata", test_name), records[exp_at+3], rdata);
            check_value($sformatf("%s rresp", test_name), records[exp_at+4], 32'(rresp));
            check_value($sformatf("%s rlast", test_name), 32'(b == n_beats - 1), 32'(rlast));
            step();
            rready = 1'b0;
        end
    endtask

    initial begin
        int          idx;
        int          n_records;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] arg;
        logic [31:0] data;
        logic [31:0] resp;
        seed    = 96;
        rst_n   = 1'b0;
        araddr  = '0;
        arlen   = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        for (idx = 0; idx < MAX_RECORDS * 5; idx++) begin
            records[idx] = '0;
        end
        $readmemh("test/axi_mem_testdata.hex", records);
        n_records = 0;
        while (n_records < MAX_RECORDS && records[n_records*5] != OP_END) begin
            n_records++;
        end
        cycle_limit = CYCLES_PER_RECORD * (n_records + 1);

        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;
        check_value("reset arready", 32'd1, 32'(arready));
        check_value("reset awready", 32'd1, 32'(awready));
        check_value("reset wready", 32'd1, 32'(wready));
        check_value("reset rvalid", 32'd0, 32'(rvalid));
        check_value("reset bvalid", 32'd0, 32'(bvalid));

        idx = 0;
        while (idx < MAX_RECORDS && records[idx*5] != OP_END) begin
            op   = records[idx*5];
            addr = records[idx*5+1];
            arg  = records[idx*5+2];
            data = records[idx*5+3];
            resp = records[idx*5+4];
            case (op)
                OP_WRITE, OP_WR_AFIRST, OP_WR_DFIRST, OP_UART: begin
                    test_name = $sformatf("record %0d write %h", idx, addr);
                    if (op == OP_WR_AFIRST) begin
                        send_addr(addr);
                        send_data(data, arg[3:0]);
                    end else if (op == OP_WR_DFIRST) begin
                        send_data(data, arg[3:0]);
                        send_addr(addr);
                    end else begin
                        send_both(addr, data, arg[3:0]);
                    end
                    take_bresp(resp);
                    if (op == OP_UART) begin
                        check_value($sformatf("%s uart pulses", test_name), 32'd1,
                                    32'(uart_seen.size()));
                        check_value($sformatf("%s uart byte", test_name), 32'(data[7:0]),
                                    32'(uart_seen.pop_front()));
                    end else begin
                        check_value($sformatf("%s uart pulses", test_name), 32'd0,
                                    32'(uart_seen.size()));
                    end
                    idx = idx + 1;
                end
                OP_READ: begin
                    run_read(idx, addr, arg);
                    idx = idx + int'(arg[7:0]) + 2;
                end
                default: begin
                    stop_run($sformatf("record %0d has an unknown op %h", idx, op));
                end
            endcase
        end

        step();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/axi_mem_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_asserts (
    input logic               clock,
    input logic               rst_n,
    input soc_mem_pkg::data_t rdata,
    input soc_mem_pkg::resp_t rresp,
    input logic               rlast,
    input logic               rvalid,
    input logic               rready,
    input soc_mem_pkg::resp_t bresp,
    input logic               bvalid,
    input logic               bready,
    input logic               uart_valid
);

    // a read beat stays put until the master takes it
    rvalid_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp) && $stable(rlast))
    ) else $error("read beat changed or dropped before rready");

    bvalid_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
        (bvalid && !bready) |=> (bvalid && $stable(bresp))
    ) else $error("write response changed or dropped before bready");

    rlast_needs_rvalid: assert property (
        @(posedge clock) disable iff (!rst_n)
        rlast |-> rvalid
    ) else $error("rlast high without rvalid");

    // one character per write
    uart_single_cycle: assert property (
        @(posedge clock) disable iff (!rst_n)
        uart_valid |=> !uart_valid
    ) else $error("uart_valid held for more than one cycle");

    quiet_in_reset: assert property (
        @(posedge clock)
        !rst_n |-> (!rvalid && !bvalid && !uart_valid)
    ) else $error("valid output high during reset");

endmodule

`default_nettype wire

// ==== design/axi_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_top #(
    parameter soc_mem_pkg::addr_t FLASH_BASE  = 32'h3000_0000,
    parameter int unsigned        FLASH_WORDS = 1024,
    parameter soc_mem_pkg::addr_t SDRAM_BASE  = 32'ha000_0000,
    parameter int unsigned        SDRAM_WORDS = 1024,
    parameter soc_mem_pkg::addr_t UART_BASE   = 32'h1000_0000
) (
    input  logic               clock,
    input  logic               rst_n,
    input  soc_mem_pkg::addr_t araddr,
    input  soc_mem_pkg::len_t  arlen,
    input  logic               arvalid,
    output logic               arready,
    output soc_mem_pkg::data_t rdata,
    output soc_mem_pkg::resp_t rresp,
    output logic               rlast,
    output logic               rvalid,
    input  logic               rready,
    input  soc_mem_pkg::addr_t awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  soc_mem_pkg::data_t wdata,
    input  soc_mem_pkg::strb_t wstrb,
    input  logic               wvalid,
    output logic               wready,
    output soc_mem_pkg::resp_t bresp,
    output logic               bvalid,
    input  logic               bready,
    output logic [7:0]         uart_data,
    output logic               uart_valid
);

    soc_mem_pkg::addr_t     rd_dec_addr;
    soc_mem_pkg::region_t   rd_dec_region;
    soc_mem_pkg::word_idx_t rd_dec_idx;
    soc_mem_pkg::addr_t     wr_dec_addr;
    soc_mem_pkg::region_t   wr_dec_region;
    soc_mem_pkg::word_idx_t wr_dec_idx;

    logic                   rd_en;
    logic                   rd_sel;
    soc_mem_pkg::word_idx_t rd_idx;
    soc_mem_pkg::data_t     flash_rd_data;
    soc_mem_pkg::data_t     sdram_rd_data;

    logic                   flash_wr;
    logic                   sdram_wr;
    soc_mem_pkg::word_idx_t wr_idx;
    soc_mem_pkg::data_t     wr_data;
    soc_mem_pkg::strb_t     wr_strb;

    addr_region_decode #(
        .FLASH_BASE  (FLASH_BASE),
        .FLASH_WORDS (FLASH_WORDS),
        .SDRAM_BASE  (SDRAM_BASE),
        .SDRAM_WORDS (SDRAM_WORDS),
        .UART_BASE   (UART_BASE)
    ) rd_decode (
        .addr     (rd_dec_addr),
        .region   (rd_dec_region),
        .word_idx (rd_dec_idx)
    );

    addr_region_decode #(
        .FLASH_BASE  (FLASH_BASE),
        .FLASH_WORDS (FLASH_WORDS),
        .SDRAM_BASE  (SDRAM_BASE),
        .SDRAM_WORDS (SDRAM_WORDS),
        .UART_BASE   (UART_BASE)
    ) wr_decode (
        .addr     (wr_dec_addr),
        .region   (wr_dec_region),
        .word_idx (wr_dec_idx)
    );

    // rd_sel steers the read enable to one bank
    mem_bank #(
        .WORDS (FLASH_WORDS)
    ) flash_bank (
        .clock   (clock),
        .rd_en   (rd_en && !rd_sel),
        .rd_idx  (rd_idx),
        .rd_data (flash_rd_data),
        .wr_en   (flash_wr),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .wr_strb (wr_strb)
    );

    mem_bank #(
        .WORDS (SDRAM_WORDS)
    ) sdram_bank (
        .clock   (clock),
        .rd_en   (rd_en && rd_sel),
        .rd_idx  (rd_idx),
        .rd_data (sdram_rd_data),
        .wr_en   (sdram_wr),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .wr_strb (wr_strb)
    );

    axi_read_engine u_read_engine (
        .clock         (clock),
        .rst_n         (rst_n),
        .araddr        (araddr),
        .arlen         (arlen),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rlast         (rlast),
        .rvalid        (rvalid),
        .rready        (rready),
        .dec_addr      (rd_dec_addr),
        .dec_region    (rd_dec_region),
        .dec_idx       (rd_dec_idx),
        .rd_en         (rd_en),
        .rd_idx        (rd_idx),
        .rd_sel        (rd_sel),
        .flash_rd_data (flash_rd_data),
        .sdram_rd_data (sdram_rd_data)
    );

    axi_write_engine u_write_engine (
        .clock      (clock),
        .rst_n      (rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .dec_addr   (wr_dec_addr),
        .dec_region (wr_dec_region),
        .dec_idx    (wr_dec_idx),
        .flash_wr   (flash_wr),
        .sdram_wr   (sdram_wr),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .wr_strb    (wr_strb),
        .uart_data  (uart_data),
        .uart_valid (uart_valid)
    );

endmodule

`default_nettype wire

// ==== design/axi_write_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_write_engine (
    input  logic                   clock,
    input  logic                   rst_n,
    input  soc_mem_pkg::addr_t     awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  soc_mem_pkg::data_t     wdata,
    input  soc_mem_pkg::strb_t     wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output soc_mem_pkg::resp_t     bresp,
    output logic                   bvalid,
    input  logic                   bready,
    output soc_mem_pkg::addr_t     dec_addr,
    input  soc_mem_pkg::region_t   dec_region,
    input  soc_mem_pkg::word_idx_t dec_idx,
    output logic                   flash_wr,
    output logic                   sdram_wr,
    output soc_mem_pkg::word_idx_t wr_idx,
    output soc_mem_pkg::data_t     wr_data,
    output soc_mem_pkg::strb_t     wr_strb,
    output logic [7:0]             uart_data,
    output logic                   uart_valid
);

    typedef enum logic [2:0] {
        W_IDLE,
        W_WAIT_ADDR,
        W_WAIT_DATA,
        W_WRITE,
        W_RESP
    } wr_state_t;

    wr_state_t          state;
    soc_mem_pkg::addr_t addr_q;
    soc_mem_pkg::data_t data_q;
    soc_mem_pkg::strb_t strb_q;
    soc_mem_pkg::resp_t bresp_q;
    logic               aw_hs;
    logic               w_hs;
    logic               writing;

    // a channel already taken drops its ready until the response is done
    assign awready = (state == W_IDLE) || (state == W_WAIT_ADDR);
    assign wready  = (state == W_IDLE) || (state == W_WAIT_DATA);
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign writing = (state == W_WRITE);

    assign dec_addr = addr_q;

    assign flash_wr   = writing && (dec_region == soc_mem_pkg::REGION_FLASH);
    assign sdram_wr   = writing && (dec_region == soc_mem_pkg::REGION_SDRAM);
    assign wr_idx     = dec_idx;
    assign wr_data    = data_q;
    assign wr_strb    = strb_q;

    // one cycle pulse per character
    assign uart_valid = writing && (dec_region == soc_mem_pkg::REGION_UART);
    assign uart_data  = data_q[7:0];

    assign bvalid = (state == W_RESP);
    assign bresp  = bresp_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= W_IDLE;
        end else begin
            case (state)
                W_IDLE: begin
                    if (aw_hs && w_hs) begin
                        state <= W_WRITE;
                    end else if (aw_hs) begin
                        state <= W_WAIT_DATA;
                    end else if (w_hs) begin
                        state <= W_WAIT_ADDR;
                    end
                end
                W_WAIT_ADDR: begin
                    if (aw_hs) begin
                        state <= W_WRITE;
                    end
                end
                W_WAIT_DATA: begin
                    if (w_hs) begin
                        state <= W_WRITE;
                    end
                end
                W_WRITE: begin
                    state <= W_RESP;
                end
                W_RESP: begin
                    if (bready) begin
                        state <= W_IDLE;
                    end
                end
                default: begin
                    state <= W_IDLE;
                end
            endcase
        end
    end

    // address and data land in whichever order they come
    always_ff @(posedge clock) begin
        if (aw_hs) begin
            addr_q <= awaddr;
        end
        if (w_hs) begin
            data_q <= wdata;
            strb_q <= wstrb;
        end
        // unmapped writes are dropped
        if (writing) begin
            bresp_q <= (dec_region == soc_mem_pkg::REGION_NONE) ?
                       soc_mem_pkg::RESP_SLVERR : soc_mem_pkg::RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

// ==== design/axi_read_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_read_engine (
    input  logic                   clock,
    input  logic                   rst_n,
    input  soc_mem_pkg::addr_t     araddr,
    input  soc_mem_pkg::len_t      arlen,
    input  logic                   arvalid,
    output logic                   arready,
    output soc_mem_pkg::data_t     rdata,
    output soc_mem_pkg::resp_t     rresp,
    output logic                   rlast,
    output logic                   rvalid,
    input  logic                   rready,
    output soc_mem_pkg::addr_t     dec_addr,
    input  soc_mem_pkg::region_t   dec_region,
    input  soc_mem_pkg::word_idx_t dec_idx,
    output logic                   rd_en,
    output soc_mem_pkg::word_idx_t rd_idx,
    output logic                   rd_sel,
    input  soc_mem_pkg::data_t     flash_rd_data,
    input  soc_mem_pkg::data_t     sdram_rd_data
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_FETCH,
        R_BEAT
    } rd_state_t;

    rd_state_t            state;
    soc_mem_pkg::addr_t   cur_addr;
    soc_mem_pkg::len_t    beat_len;
    soc_mem_pkg::len_t    beat_cnt;
    soc_mem_pkg::region_t beat_region;
    logic                 ar_hs;
    logic                 r_hs;
    logic                 bank_hit;
    logic                 fetching;

    assign arready = (state == R_IDLE);
    assign rvalid  = (state == R_BEAT);
    assign ar_hs   = arvalid && arready;
    assign r_hs    = rvalid && rready;
    assign rlast   = rvalid && (beat_cnt == beat_len);

    // in idle the incoming address is decoded so the first word is read on the handshake
    assign dec_addr = (state == R_IDLE) ? araddr : cur_addr;
    assign fetching = ar_hs || (state == R_FETCH);

    assign bank_hit = (dec_region == soc_mem_pkg::REGION_FLASH) ||
                      (dec_region == soc_mem_pkg::REGION_SDRAM);
    assign rd_en    = fetching && bank_hit;
    assign rd_idx   = dec_idx;
    assign rd_sel   = (dec_region == soc_mem_pkg::REGION_SDRAM);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= R_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (ar_hs) begin
                        state    <= R_BEAT;
                        beat_cnt <= '0;
                    end
                end
                R_BEAT: begin
                    if (r_hs) begin
                        if (rlast) begin
                            state <= R_IDLE;
                        end else begin
                            state    <= R_FETCH;
                            beat_cnt <= beat_cnt + 8'd1;
                        end
                    end
                end
                R_FETCH: begin
                    state <= R_BEAT;
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

    // burst address steps one word per beat
    always_ff @(posedge clock) begin
        if (ar_hs) begin
            cur_addr <= araddr;
            beat_len <= arlen;
        end else if (r_hs && !rlast) begin
            cur_addr <= cur_addr + 32'd4;
        end
        if (fetching) begin
            beat_region <= dec_region;
        end
    end

    // unmapped and uart beats carry zero with SLVERR
    always_comb begin
        rdata = '0;
        rresp = soc_mem_pkg::RESP_SLVERR;
        case (beat_region)
            soc_mem_pkg::REGION_FLASH: begin
                rdata = flash_rd_data;
                rresp = soc_mem_pkg::RESP_OKAY;
            end
            soc_mem_pkg::REGION_SDRAM: begin
                rdata = sdram_rd_data;
                rresp = soc_mem_pkg::RESP_OKAY;
            end
            default: begin
                rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/mem_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
    parameter int unsigned WORDS = 1024
) (
    input  logic                   clock,
    input  logic                   rd_en,
    input  soc_mem_pkg::word_idx_t rd_idx,
    output soc_mem_pkg::data_t     rd_data,
    input  logic                   wr_en,
    input  soc_mem_pkg::word_idx_t wr_idx,
    input  soc_mem_pkg::data_t     wr_data,
    input  soc_mem_pkg::strb_t     wr_strb
);

    localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

    soc_mem_pkg::data_t mem [WORDS];

    logic [IDX_W-1:0] rd_addr;
    logic [IDX_W-1:0] wr_addr;

    // decoder keeps the index inside the bank
    assign rd_addr = rd_idx[IDX_W-1:0];
    assign wr_addr = wr_idx[IDX_W-1:0];

    // registered read returns old data on a same-word write
    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // only strobed byte lanes change
    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wr_strb[lane]) begin
                    mem[wr_addr][8*lane +: 8] <= wr_data[8*lane +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/addr_region_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_region_decode #(
    parameter soc_mem_pkg::addr_t FLASH_BASE  = 32'h3000_0000,
    parameter int unsigned        FLASH_WORDS = 1024,
    parameter soc_mem_pkg::addr_t SDRAM_BASE  = 32'ha000_0000,
    parameter int unsigned        SDRAM_WORDS = 1024,
    parameter soc_mem_pkg::addr_t UART_BASE   = 32'h1000_0000
) (
    input  soc_mem_pkg::addr_t     addr,
    output soc_mem_pkg::region_t   region,
    output soc_mem_pkg::word_idx_t word_idx
);

    localparam soc_mem_pkg::addr_t FLASH_BYTES = soc_mem_pkg::addr_t'(FLASH_WORDS * 4);
    localparam soc_mem_pkg::addr_t SDRAM_BYTES = soc_mem_pkg::addr_t'(SDRAM_WORDS * 4);

    soc_mem_pkg::addr_t flash_off;
    soc_mem_pkg::addr_t sdram_off;
    logic               in_flash;
    logic               in_sdram;
    logic               in_uart;

    assign flash_off = addr - FLASH_BASE;
    assign sdram_off = addr - SDRAM_BASE;

    // offset wraps when addr is below the base, so check both bounds
    assign in_flash = (addr >= FLASH_BASE) && (flash_off < FLASH_BYTES);
    assign in_sdram = (addr >= SDRAM_BASE) && (sdram_off < SDRAM_BYTES);

    // uart is a single word
    assign in_uart  = (addr[31:2] == UART_BASE[31:2]);

    always_comb begin
        region   = soc_mem_pkg::REGION_NONE;
        word_idx = '0;
        if (in_flash) begin
            region   = soc_mem_pkg::REGION_FLASH;
            word_idx = flash_off[21:2];
        end else if (in_sdram) begin
            region   = soc_mem_pkg::REGION_SDRAM;
            word_idx = sdram_off[21:2];
        end else if (in_uart) begin
            region   = soc_mem_pkg::REGION_UART;
        end
    end

endmodule

`default_nettype wire

// ==== design/soc_mem_pkg.sv ====
`default_nettype none

package soc_mem_pkg;

    // bus field widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // burst length as carried on arlen in beats minus one
    typedef logic [7:0]  len_t;

    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // which target an address falls into
    typedef logic [1:0]  region_t;

    localparam region_t REGION_NONE  = 2'd0;
    localparam region_t REGION_FLASH = 2'd1;
    localparam region_t REGION_SDRAM = 2'd2;
    localparam region_t REGION_UART  = 2'd3;

    // up to 1M words per bank
    typedef logic [19:0] word_idx_t;

endpackage

`default_nettype wire
